// ==== ofdm_payload_rx.f ====
verilog/ofdm_rx_pkg.sv
verilog/ofdm_carrier_select.sv
verilog/ofdm_demapper.sv
verilog/ofdm_byte_buffer.sv
verilog/ofdm_payload_rx.sv
tb/tb_clock_gen.sv
tb/ofdm_payload_rx_properties.sv
tb/tb_ofdm_payload_rx.sv

// ==== tb/tb_ofdm_payload_rx.sv ====
module tb_ofdm_payload_rx;
    import ofdm_rx_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    localparam int TIMEOUT     = 2000;
    localparam int OUT_LATENCY = 3;

    logic                clk;
    logic                reset;
    logic                sample_valid_i;
    logic [SAMPLE_W-1:0] sample_i_i;
    logic [SAMPLE_W-1:0] sample_q_i;
    modulation_t         modulation_i;
    logic                out_ready_i;
    logic                out_valid_o;
    logic [7:0]          out_data_o;
    logic                payload_done_o;

    // Symbol as sent, one entry per bin
    logic [SAMPLE_W-1:0] sym_i [N_BINS];
    logic [SAMPLE_W-1:0] sym_q [N_BINS];

    byte_q_t exp_q;
    logic    ready_full = 1'b1;
    int      xfer_cnt   = 0;
    int      byte_cnt   = 0;
    int      err_cnt    = 0;

    tb_clock_gen i_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    ofdm_payload_rx i_ofdm_payload_rx (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_i_i     (sample_i_i),
        .sample_q_i     (sample_q_i),
        .modulation_i   (modulation_i),
        .out_ready_i    (out_ready_i),
        .out_valid_o    (out_valid_o),
        .out_data_o     (out_data_o),
        .payload_done_o (payload_done_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Data subcarriers in bin order, sign bit 0 decides 1, LSB first
    function automatic byte_q_t expected_payload(
        input logic [SAMPLE_W-1:0] si [N_BINS],
        input logic [SAMPLE_W-1:0] sq [N_BINS],
        input modulation_t         m
    );
        byte_q_t    result;
        logic [7:0] acc;
        int         n;
        n = 0;
        for (int b = 0; b < N_BINS; b++)
        begin
            if (CARRIER_MASK[b])
            begin
                acc[n] = ~si[b][SAMPLE_W-1];
                n++;
                if (m == MOD_QPSK)
                begin
                    acc[n] = ~sq[b][SAMPLE_W-1];
                    n++;
                end
                if (n == 8)
                begin
                    result.push_back(acc);
                    n = 0;
                end
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic build_symbol(input logic extreme);
        for (int b = 0; b < N_BINS; b++)
        begin
            if (extreme && !CARRIER_MASK[b])
            begin
                // Full scale of alternating sign on pilots and nulls
                sym_i[b] = b[0] ? 16'h8000 : 16'h7fff;
                sym_q[b] = b[0] ? 16'h7fff : 16'h8000;
            end
            else
            begin
                sym_i[b] = SAMPLE_W'($urandom);
                sym_q[b] = SAMPLE_W'($urandom);
            end
        end
    endtask

    // Samples that the DUT has to drop
    task automatic drive_junk(input modulation_t m);
        sample_valid_i = 1'($urandom);
        sample_i_i     = SAMPLE_W'($urandom);
        sample_q_i     = SAMPLE_W'($urandom);
        modulation_i   = (m == MOD_QPSK) ? MOD_BPSK : MOD_QPSK;
    endtask

    task automatic send_symbol(input modulation_t m);
        int gap;
        for (int b = 0; b < N_BINS; b++)
        begin
            gap = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
            sample_valid_i = 1'b0;
            repeat (gap) @(negedge clk);
            sample_valid_i = 1'b1;
            sample_i_i     = sym_i[b];
            sample_q_i     = sym_q[b];
            modulation_i   = m;
            @(negedge clk);
        end
        sample_valid_i = 1'b0;
    endtask

    task automatic run_symbol(input modulation_t m, input logic extreme, input logic full_rate);
        int cycles;
        int exp_len;
        exp_len = (m == MOD_QPSK) ? MAX_BYTES : MAX_BYTES / 2;
        build_symbol(extreme);
        exp_q      = expected_payload(sym_i, sym_q, m);
        xfer_cnt   = 0;
        ready_full = full_rate;
        send_symbol(m);

        // Falling edges counted from the one that drove bin 255
        cycles = 1;
        while (!out_valid_o && cycles < TIMEOUT)
        begin
            drive_junk(m);
            @(negedge clk);
            cycles++;
        end
        if (!out_valid_o)
        begin
            stop_on_timeout("out_valid_o never rose after the last bin");
        end
        if (cycles != OUT_LATENCY)
        begin
            $display("Error at %0t: out_valid_o latency = %0d, expected %0d",
                     $time, cycles, OUT_LATENCY);
            err_cnt++;
        end

        cycles = 0;
        while (!payload_done_o && cycles < TIMEOUT)
        begin
            drive_junk(m);
            @(negedge clk);
            cycles++;
        end
        sample_valid_i = 1'b0;
        if (!payload_done_o)
        begin
            stop_on_timeout("payload_done_o never pulsed during readout");
        end
        if (xfer_cnt != exp_len)
        begin
            $display("Error at %0t: byte count = %0d, expected %0d", $time, xfer_cnt, exp_len);
            err_cnt++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output checking and back-pressure
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [7:0] want;
        logic       done_due;
        done_due    = 1'b0;
        out_ready_i = 1'b0;
        forever
        begin
            @(negedge clk);
            // Done pulse belongs to the cycle right after the last transfer
            if (payload_done_o !== done_due)
            begin
                $display("Error at %0t: payload_done_o = %b, expected %b",
                         $time, payload_done_o, done_due);
                err_cnt++;
            end
            done_due    = 1'b0;
            out_ready_i = ready_full ? 1'b1 : 1'($urandom % 3 != 0);
            // This byte moves on the coming rising edge
            if (out_valid_o && out_ready_i)
            begin
                xfer_cnt++;
                byte_cnt++;
                if (exp_q.size() == 0)
                begin
                    $display("Extra byte %h at %0t beyond the expected payload",
                             out_data_o, $time);
                    err_cnt++;
                end
                else
                begin
                    want     = exp_q.pop_front();
                    done_due = (exp_q.size() == 0);
                    if (out_data_o !== want)
                    begin
                        $display("Error at %0t: out_data_o = %h, expected %h",
                                 $time, out_data_o, want);
                        err_cnt++;
                    end
                end
            end
        end
    end

    initial
    begin
        int cycles;
        int fails;
        void'($urandom(92));
        sample_valid_i = 1'b0;
        sample_i_i     = '0;
        sample_q_i     = '0;
        modulation_i   = MOD_BPSK;

        cycles = 0;
        while (reset !== 1'b0 && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0)
        begin
            stop_on_timeout("reset was never released");
        end

        run_symbol(MOD_BPSK, 1'b0, 1'b1);
        run_symbol(MOD_QPSK, 1'b0, 1'b0);
        run_symbol(MOD_BPSK, 1'b1, 1'b0);
        run_symbol(MOD_QPSK, 1'b1, 1'b0);

        fails = i_ofdm_payload_rx.i_properties.fail_cnt;
        $display("Bytes checked: %0d, errors: %0d, assertion failures: %0d",
                 byte_cnt, err_cnt, fails);
        if (err_cnt == 0 && fails == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/ofdm_payload_rx_properties.sv ====
module ofdm_payload_rx_properties (
    input logic       clk,
    input logic       reset,
    input logic       group_valid_i,
    input logic       bits_valid_i,
    input logic       out_valid_i,
    input logic       out_ready_i,
    input logic [7:0] out_data_i,
    input logic       payload_done_i
);
    // Failed assertions so far, read by the testbench top
    int fail_cnt = 0;

    group_pulse: assert property (@(posedge clk) disable iff (reset)
        group_valid_i |=> !group_valid_i)
    else
    begin
        $error("group_valid stayed high for more than one cycle");
        fail_cnt++;
    end

    bits_pulse: assert property (@(posedge clk) disable iff (reset)
        bits_valid_i |=> !bits_valid_i)
    else
    begin
        $error("bits_valid stayed high for more than one cycle");
        fail_cnt++;
    end

    // A stalled byte stays offered and unchanged
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else
    begin
        $error("out_data_o or out_valid_o changed while stalled");
        fail_cnt++;
    end

    done_alone: assert property (@(posedge clk) disable iff (reset)
        !(payload_done_i && out_valid_i))
    else
    begin
        $error("payload_done_o coincides with out_valid_o");
        fail_cnt++;
    end

endmodule

bind ofdm_payload_rx ofdm_payload_rx_properties i_properties (
    .clk            (clk),
    .reset          (reset),
    .group_valid_i  (group_valid),
    .bits_valid_i   (bits_valid),
    .out_valid_i    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_data_i     (out_data_o),
    .payload_done_i (payload_done_o)
);

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    localparam int HALF_PERIOD = 20;

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // Reset covers the first two rising edges
    initial
    begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== verilog/ofdm_payload_rx.sv ====
module ofdm_payload_rx (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             sample_valid_i,
    input  logic [ofdm_rx_pkg::SAMPLE_W-1:0] sample_i_i,
    input  logic [ofdm_rx_pkg::SAMPLE_W-1:0] sample_q_i,
    input  ofdm_rx_pkg::modulation_t         modulation_i,
    input  logic                             out_ready_i,
    output logic                             out_valid_o,
    output logic [7:0]                       out_data_o,
    output logic                             payload_done_o
);
    import ofdm_rx_pkg::*;

    // Selector to demapper
    logic                group_valid;
    logic [SAMPLE_W-1:0] group_i [GROUP_SIZE];
    logic [SAMPLE_W-1:0] group_q [GROUP_SIZE];
    modulation_t         group_mod;

    // Demapper to buffer
    logic                bits_valid;
    logic [15:0]         bits;
    modulation_t         bits_mod;

    // Buffer back to selector
    logic                buffer_busy;

    //////////////////////////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////////////////////////

    ofdm_carrier_select i_carrier_select (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_i_i     (sample_i_i),
        .sample_q_i     (sample_q_i),
        .modulation_i   (modulation_i),
        .buffer_busy_i  (buffer_busy),
        .group_valid_o  (group_valid),
        .group_i_o      (group_i),
        .group_q_o      (group_q),
        .group_mod_o    (group_mod)
    );

    ofdm_demapper i_demapper (
        .clk           (clk),
        .reset         (reset),
        .group_valid_i (group_valid),
        .group_i_i     (group_i),
        .group_q_i     (group_q),
        .group_mod_i   (group_mod),
        .bits_valid_o  (bits_valid),
        .bits_o        (bits),
        .bits_mod_o    (bits_mod)
    );

    ofdm_byte_buffer i_byte_buffer (
        .clk            (clk),
        .reset          (reset),
        .bits_valid_i   (bits_valid),
        .bits_i         (bits),
        .bits_mod_i     (bits_mod),
        .out_ready_i    (out_ready_i),
        .buffer_busy_o  (buffer_busy),
        .out_valid_o    (out_valid_o),
        .out_data_o     (out_data_o),
        .payload_done_o (payload_done_o)
    );

endmodule

// ==== verilog/ofdm_byte_buffer.sv ====
module ofdm_byte_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     bits_valid_i,
    input  logic [15:0]              bits_i,
    input  ofdm_rx_pkg::modulation_t bits_mod_i,
    input  logic                     out_ready_i,
    output logic                     buffer_busy_o,
    output logic                     out_valid_o,
    output logic [7:0]               out_data_o,
    output logic                     payload_done_o
);
    import ofdm_rx_pkg::*;

    // Payload of one symbol, byte 0 first
    logic [7:0]                  mem [MAX_BYTES];

    logic [BYTE_CNT_W-1:0]       wr_ptr;
    logic [BYTE_CNT_W-1:0]       rd_ptr;
    // Number of bytes held for the current symbol
    logic [BYTE_CNT_W-1:0]       len_q;
    logic [$clog2(N_GROUPS)-1:0] grp_cnt;

    logic                        write_en;
    logic                        last_group;
    logic                        last_byte;
    logic                        transfer;
    logic [BYTE_CNT_W-1:0]       step;
    logic [BYTE_CNT_W-1:0]       next_wr;

    assign write_en   = bits_valid_i & ~buffer_busy_o;
    assign last_group = (grp_cnt == N_GROUPS - 1);
    assign transfer   = out_valid_o & out_ready_i;
    assign last_byte  = (rd_ptr == len_q - 1'b1);

    // One byte per group for BPSK, two for QPSK
    assign step    = (bits_mod_i == MOD_QPSK) ? BYTE_CNT_W'(2) : BYTE_CNT_W'(1);
    assign next_wr = wr_ptr + step;

    // Read pointer only moves on a transfer, which keeps the byte steady
    // while the consumer stalls
    assign out_data_o = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            // LSB first within a byte, low byte of the word goes first
            mem[wr_ptr] <= bits_i[7:0];
            if (bits_mod_i == MOD_QPSK)
            begin
                mem[wr_ptr + 1'b1] <= bits_i[15:8];
            end

            if (last_group)
            begin
                len_q <= next_wr;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write side and readout control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            grp_cnt        <= '0;
            buffer_busy_o  <= 1'b0;
            out_valid_o    <= 1'b0;
            payload_done_o <= 1'b0;
        end
        else
        begin
            payload_done_o <= 1'b0;

            if (write_en)
            begin
                if (last_group)
                begin
                    // Symbol complete, switch over to readout
                    grp_cnt       <= '0;
                    wr_ptr        <= '0;
                    buffer_busy_o <= 1'b1;
                    out_valid_o   <= 1'b1;
                end
                else
                begin
                    grp_cnt <= grp_cnt + 1'b1;
                    wr_ptr  <= next_wr;
                end
            end

            if (transfer)
            begin
                if (last_byte)
                begin
                    // Back to idle, next sample is bin 0 again
                    rd_ptr         <= '0;
                    out_valid_o    <= 1'b0;
                    buffer_busy_o  <= 1'b0;
                    payload_done_o <= 1'b1;
                end
                else
                begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/ofdm_demapper.sv ====
module ofdm_demapper (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             group_valid_i,
    input  logic [ofdm_rx_pkg::SAMPLE_W-1:0] group_i_i [ofdm_rx_pkg::GROUP_SIZE],
    input  logic [ofdm_rx_pkg::SAMPLE_W-1:0] group_q_i [ofdm_rx_pkg::GROUP_SIZE],
    input  ofdm_rx_pkg::modulation_t         group_mod_i,
    output logic                             bits_valid_o,
    output logic [15:0]                      bits_o,
    output ofdm_rx_pkg::modulation_t         bits_mod_o
);
    import ofdm_rx_pkg::*;

    logic [GROUP_SIZE-1:0]   bpsk_bits;
    logic [2*GROUP_SIZE-1:0] qpsk_bits;

    //////////////////////////////////////////////////////////////////////
    // Hard decisions
    //////////////////////////////////////////////////////////////////////

    // A non-negative component decides 1, so the bit is the inverted sign
    always_comb
    begin
        for (int j = 0; j < GROUP_SIZE; j++)
        begin
            bpsk_bits[j]       = ~group_i_i[j][SAMPLE_W-1];
            // I on the even bit, Q on the odd bit
            qpsk_bits[2*j]     = ~group_i_i[j][SAMPLE_W-1];
            qpsk_bits[2*j + 1] = ~group_q_i[j][SAMPLE_W-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bits_valid_o <= 1'b0;
        end
        else
        begin
            bits_valid_o <= group_valid_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (group_valid_i)
        begin
            bits_mod_o <= group_mod_i;
            if (group_mod_i == MOD_QPSK)
            begin
                bits_o <= qpsk_bits;
            end
            else
            begin
                // BPSK only fills the low byte
                bits_o <= {8'h00, bpsk_bits};
            end
        end
    end

endmodule

// ==== verilog/ofdm_carrier_select.sv ====
module ofdm_carrier_select (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             sample_valid_i,
    input  logic [ofdm_rx_pkg::SAMPLE_W-1:0] sample_i_i,
    input  logic [ofdm_rx_pkg::SAMPLE_W-1:0] sample_q_i,
    input  ofdm_rx_pkg::modulation_t         modulation_i,
    input  logic                             buffer_busy_i,
    output logic                             group_valid_o,
    output logic [ofdm_rx_pkg::SAMPLE_W-1:0] group_i_o [ofdm_rx_pkg::GROUP_SIZE],
    output logic [ofdm_rx_pkg::SAMPLE_W-1:0] group_q_o [ofdm_rx_pkg::GROUP_SIZE],
    output ofdm_rx_pkg::modulation_t         group_mod_o
);
    import ofdm_rx_pkg::*;

    // Position inside the current symbol
    logic [BIN_W-1:0]              bin_cnt;
    // Next free entry of the group register file
    logic [$clog2(GROUP_SIZE)-1:0] slot_cnt;
    // Set once bin 255 is taken, until the buffer reports busy
    logic                          symbol_full;
    logic                          accept;
    logic                          is_data;
    logic                          last_bin;
    logic                          last_slot;

    // Input is dropped while the previous symbol is still in flight or reading out
    assign accept    = sample_valid_i & ~buffer_busy_i & ~symbol_full;
    assign is_data   = CARRIER_MASK[bin_cnt];
    assign last_bin  = (bin_cnt == N_BINS - 1);
    assign last_slot = (slot_cnt == GROUP_SIZE - 1);

    //////////////////////////////////////////////////////////////////////
    // Bin and slot counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bin_cnt       <= '0;
            slot_cnt      <= '0;
            symbol_full   <= 1'b0;
            group_valid_o <= 1'b0;
            group_mod_o   <= MOD_BPSK;
        end
        else
        begin
            group_valid_o <= 1'b0;

            if (accept)
            begin
                // Counter wraps to 0 after bin 255 by itself
                bin_cnt <= bin_cnt + 1'b1;

                if (bin_cnt == '0)
                begin
                    group_mod_o <= modulation_i;
                end

                if (is_data)
                begin
                    slot_cnt <= slot_cnt + 1'b1;
                    if (last_slot)
                    begin
                        group_valid_o <= 1'b1;
                    end
                end
            end

            // Hold off the next symbol until readout has started
            if (accept && last_bin)
            begin
                symbol_full <= 1'b1;
            end
            else if (buffer_busy_i)
            begin
                symbol_full <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Group register file
    //////////////////////////////////////////////////////////////////////

    // Entry 7 is written on the edge that raises group_valid_o, so the
    // whole group is stable while the strobe is high
    always_ff @(posedge clk)
    begin
        if (accept && is_data)
        begin
            group_i_o[slot_cnt] <= sample_i_i;
            group_q_o[slot_cnt] <= sample_q_i;
        end
    end

endmodule

// ==== verilog/ofdm_rx_pkg.sv ====
package ofdm_rx_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    // I and Q sample width from the FFT
    localparam int SAMPLE_W = 16;

    localparam int N_BINS = 256;
    localparam int BIN_W  = 8;

    // Subcarriers handed to the demapper at once
    localparam int GROUP_SIZE = 8;

    // 192 data subcarriers / 8
    localparam int N_GROUPS = 24;

    // QPSK payload, also the buffer depth
    localparam int MAX_BYTES  = 48;
    localparam int BYTE_CNT_W = 6;

    //////////////////////////////////////////////////////////////////////
    // Subcarrier map
    //////////////////////////////////////////////////////////////////////

    // Bin layout of one 256-point symbol:
    //   0        DC, unused
    //   1..100   positive payload subcarriers
    //   101..155 guard band, unused
    //   156..255 negative payload subcarriers
    localparam logic [N_BINS-1:0] PAYLOAD_MASK =
        {{100{1'b1}}, {55{1'b0}}, {100{1'b1}}, 1'b0};

    // Pilots at +-13, +-38, +-63, +-88
    localparam logic [N_BINS-1:0] PILOT_MASK =
        (N_BINS'(1) << 13)  |
        (N_BINS'(1) << 38)  |
        (N_BINS'(1) << 63)  |
        (N_BINS'(1) << 88)  |
        (N_BINS'(1) << 168) |
        (N_BINS'(1) << 193) |
        (N_BINS'(1) << 218) |
        (N_BINS'(1) << 243);

    // One bit per bin, set where a data subcarrier sits
    localparam logic [N_BINS-1:0] CARRIER_MASK = PAYLOAD_MASK & ~PILOT_MASK;

    //////////////////////////////////////////////////////////////////////
    // Modulation
    //////////////////////////////////////////////////////////////////////

    // BPSK carries 1 bit per subcarrier, QPSK 2 bits
    typedef enum logic [0:0] {
        MOD_BPSK = 1'b0,
        MOD_QPSK = 1'b1
    } modulation_t;

endpackage
